// ==== include/arena_defs.svh ====
`ifndef ARENA_DEFS_SVH
`define ARENA_DEFS_SVH

// arena in pixels
`define ARENA_W 320
`define ARENA_H 240

`define CHAR_SIZE 20           // fighter box side
`define PROJ_SIZE 8            // projectile box side
`define PROJ_OFFSET 6          // centres projectile in owner box

// per-tick steps
`define MOVE_STEP 2
`define PROJ_STEP 4

`define GAME_TICK_CYCLES 8     // clocks per game tick

`define HEALTH_START 8

// projectile lifetimes in ticks
`define LIFE_MAGE 100
`define LIFE_GUNMAN 150
`define LIFE_SWORDMAN 100
`define LIFE_FISTMAN 50

`define N_FIGHTERS 4

`endif

// ==== rtl/arena_pkg.sv ====
`default_nettype none

package arena_pkg;

    typedef logic [9:0] pos_t;         // screen coordinate

    typedef enum logic [1:0] {
        dir_up    = 2'd0,
        dir_down  = 2'd1,
        dir_left  = 2'd2,
        dir_right = 2'd3
    } dir_t;

    typedef logic [3:0] health_t;

    // 0 mage, 1 gunman, 2 swordman, 3 fistman
    typedef logic [1:0] fighter_idx_t;

    typedef logic [7:0] life_t;        // ticks left in flight

    // half-open boxes, so touching edges do not count
    function automatic logic boxes_overlap(
        input pos_t ax,
        input pos_t ay,
        input pos_t bx,
        input pos_t by,
        input pos_t a_size,
        input pos_t b_size
    );
        logic [10:0] a_end_x;
        logic [10:0] a_end_y;
        logic [10:0] b_end_x;
        logic [10:0] b_end_y;
        a_end_x = {1'b0, ax} + {1'b0, a_size};
        a_end_y = {1'b0, ay} + {1'b0, a_size};
        b_end_x = {1'b0, bx} + {1'b0, b_size};
        b_end_y = {1'b0, by} + {1'b0, b_size};
        return ({1'b0, ax} < b_end_x) && ({1'b0, bx} < a_end_x) &&
               ({1'b0, ay} < b_end_y) && ({1'b0, by} < a_end_y);
    endfunction

endpackage

`default_nettype wire

// ==== rtl/game_tick_gen.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "arena_defs.svh"

module game_tick_gen (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int unsigned CNT_W = $clog2(`GAME_TICK_CYCLES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`GAME_TICK_CYCLES - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            tick <= (cnt == CNT_LAST);      // one-cycle pulse at wrap
            if (cnt == CNT_LAST) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fighter_motion.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "arena_defs.svh"

module fighter_motion #(
    parameter arena_pkg::pos_t start_x = 10'd60,
    parameter arena_pkg::pos_t start_y = 10'd40
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 tick,
    input  logic                                 alive,
    input  logic                                 move_req,
    input  arena_pkg::dir_t                      move_dir,
    input  arena_pkg::pos_t [`N_FIGHTERS-2:0]    other_x,
    input  arena_pkg::pos_t [`N_FIGHTERS-2:0]    other_y,
    output arena_pkg::pos_t                      x,
    output arena_pkg::pos_t                      y,
    output arena_pkg::dir_t                      facing
);

    import arena_pkg::*;

    localparam pos_t STEP = pos_t'(`MOVE_STEP);
    localparam pos_t SIZE = pos_t'(`CHAR_SIZE);

    pos_t                    cand_x;
    pos_t                    cand_y;
    logic                    wall_hit;
    logic [`N_FIGHTERS-2:0]  box_hit;

    // candidate box one step along move_dir
    always_comb begin
        cand_x   = x;
        cand_y   = y;
        wall_hit = 1'b0;
        case (move_dir)
            dir_up: begin
                cand_y   = y - STEP;
                wall_hit = (y < STEP);
            end
            dir_down: begin
                cand_y   = y + STEP;
                wall_hit = (int'(y) + `MOVE_STEP + `CHAR_SIZE > `ARENA_H);
            end
            dir_left: begin
                cand_x   = x - STEP;
                wall_hit = (x < STEP);
            end
            default: begin
                cand_x   = x + STEP;
                wall_hit = (int'(x) + `MOVE_STEP + `CHAR_SIZE > `ARENA_W);
            end
        endcase
    end

    always_comb begin
        for (int i = 0; i < `N_FIGHTERS - 1; i++) begin
            box_hit[i] = boxes_overlap(cand_x, cand_y, other_x[i], other_y[i], SIZE, SIZE);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            x      <= start_x;
            y      <= start_y;
            facing <= dir_down;
        end else if (tick && alive && move_req) begin
            facing <= move_dir;             // turns even when blocked
            if (!wall_hit && box_hit == '0) begin
                x <= cand_x;
                y <= cand_y;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/projectile_unit.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "arena_defs.svh"

module projectile_unit #(
    parameter arena_pkg::fighter_idx_t owner    = 2'd0,
    parameter arena_pkg::life_t        lifetime = 8'd100
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 tick,
    input  logic                                 fire_req,
    input  arena_pkg::dir_t                      owner_facing,
    input  arena_pkg::pos_t [`N_FIGHTERS-1:0]    fighter_x,
    input  arena_pkg::pos_t [`N_FIGHTERS-1:0]    fighter_y,
    input  logic [`N_FIGHTERS-1:0]               alive,
    output logic                                 active,
    output arena_pkg::pos_t                      x,
    output arena_pkg::pos_t                      y,
    output arena_pkg::dir_t                      dir,
    output logic [`N_FIGHTERS-1:0]               hit
);

    import arena_pkg::*;

    localparam pos_t STEP   = pos_t'(`PROJ_STEP);
    localparam pos_t OFFSET = pos_t'(`PROJ_OFFSET);

    life_t                   life;
    pos_t                    next_x;
    pos_t                    next_y;
    logic                    edge_out;
    logic [`N_FIGHTERS-1:0]  overlap;
    logic [`N_FIGHTERS-1:0]  first_hit;

    // alive non-owner fighters under the projectile box
    always_comb begin
        for (int i = 0; i < `N_FIGHTERS; i++) begin
            overlap[i] = alive[i] && (i != int'(owner)) &&
                         boxes_overlap(x, y, fighter_x[i], fighter_y[i],
                                       pos_t'(`PROJ_SIZE), pos_t'(`CHAR_SIZE));
        end
        first_hit = overlap & (~overlap + 1'b1);   // lowest index only
    end

    always_comb begin
        next_x   = x;
        next_y   = y;
        edge_out = 1'b0;
        case (dir)
            dir_up: begin
                next_y   = y - STEP;
                edge_out = (y < STEP);
            end
            dir_down: begin
                next_y   = y + STEP;
                edge_out = (int'(y) + `PROJ_STEP + `PROJ_SIZE > `ARENA_H);
            end
            dir_left: begin
                next_x   = x - STEP;
                edge_out = (x < STEP);
            end
            default: begin
                next_x   = x + STEP;
                edge_out = (int'(x) + `PROJ_STEP + `PROJ_SIZE > `ARENA_W);
            end
        endcase
    end

    assign hit = (tick && active) ? first_hit : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            x      <= '0;
            y      <= '0;
            dir    <= dir_down;
            life   <= '0;
        end else if (tick) begin
            if (!active) begin
                if (fire_req && alive[owner]) begin
                    active <= 1'b1;         // no step on the spawn tick
                    x      <= fighter_x[owner] + OFFSET;
                    y      <= fighter_y[owner] + OFFSET;
                    dir    <= owner_facing;
                    life   <= lifetime;
                end
            end else if (first_hit != '0 || life == '0 || edge_out) begin
                active <= 1'b0;             // hit, expired or leaving
            end else begin
                x    <= next_x;
                y    <= next_y;
                life <= life - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/health_ledger.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "arena_defs.svh"

module health_ledger (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          tick,
    input  logic [`N_FIGHTERS-1:0][`N_FIGHTERS-1:0]       hits,
    output arena_pkg::health_t [`N_FIGHTERS-1:0]          health,
    output logic [`N_FIGHTERS-1:0]                        alive
);

    import arena_pkg::*;

    logic [`N_FIGHTERS-1:0][2:0]  hit_count;
    health_t [`N_FIGHTERS-1:0]    next_health;

    // hits[unit][target]
    always_comb begin
        for (int t = 0; t < `N_FIGHTERS; t++) begin
            hit_count[t] = '0;
            for (int u = 0; u < `N_FIGHTERS; u++) begin
                hit_count[t] = hit_count[t] + 3'(hits[u][t]);
            end
            if (health[t] > health_t'(hit_count[t])) begin
                next_health[t] = health[t] - health_t'(hit_count[t]);
            end else begin
                next_health[t] = '0;        // saturate
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int t = 0; t < `N_FIGHTERS; t++) begin
                health[t] <= health_t'(`HEALTH_START);
            end
        end else if (tick) begin
            health <= next_health;
        end
    end

    always_comb begin
        for (int t = 0; t < `N_FIGHTERS; t++) begin
            alive[t] = (health[t] != '0);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/arena_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "arena_defs.svh"

module arena_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [`N_FIGHTERS-1:0]               move_req,
    input  arena_pkg::dir_t [`N_FIGHTERS-1:0]    move_dir,
    input  logic [`N_FIGHTERS-1:0]               fire_req,
    output logic                                 tick,
    output arena_pkg::pos_t [`N_FIGHTERS-1:0]    fighter_x,
    output arena_pkg::pos_t [`N_FIGHTERS-1:0]    fighter_y,
    output arena_pkg::dir_t [`N_FIGHTERS-1:0]    facing,
    output logic [`N_FIGHTERS-1:0]               proj_active,
    output arena_pkg::pos_t [`N_FIGHTERS-1:0]    proj_x,
    output arena_pkg::pos_t [`N_FIGHTERS-1:0]    proj_y,
    output arena_pkg::health_t [`N_FIGHTERS-1:0] health
);

    import arena_pkg::*;

    // start corners and lifetimes, mage first
    localparam pos_t  START_X [`N_FIGHTERS] = '{10'd60, 10'd240, 10'd60, 10'd240};
    localparam pos_t  START_Y [`N_FIGHTERS] = '{10'd40, 10'd40, 10'd180, 10'd180};
    localparam life_t LIFETIME [`N_FIGHTERS] = '{
        life_t'(`LIFE_MAGE),
        life_t'(`LIFE_GUNMAN),
        life_t'(`LIFE_SWORDMAN),
        life_t'(`LIFE_FISTMAN)
    };

    logic [`N_FIGHTERS-1:0]                     alive;
    logic [`N_FIGHTERS-1:0][`N_FIGHTERS-1:0]    hits;      // [unit][target]
    pos_t [`N_FIGHTERS-1:0][`N_FIGHTERS-2:0]    other_x;
    pos_t [`N_FIGHTERS-1:0][`N_FIGHTERS-2:0]    other_y;

    game_tick_gen i_tick_gen (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    for (genvar i = 0; i < `N_FIGHTERS; i++) begin : g_fighter
        // everyone except fighter i, in index order
        for (genvar j = 0; j < `N_FIGHTERS - 1; j++) begin : g_other
            assign other_x[i][j] = fighter_x[(j < i) ? j : j + 1];
            assign other_y[i][j] = fighter_y[(j < i) ? j : j + 1];
        end

        fighter_motion #(
            .start_x (START_X[i]),
            .start_y (START_Y[i])
        ) i_motion (
            .clk      (clk),
            .rst      (rst),
            .tick     (tick),
            .alive    (alive[i]),
            .move_req (move_req[i]),
            .move_dir (move_dir[i]),
            .other_x  (other_x[i]),
            .other_y  (other_y[i]),
            .x        (fighter_x[i]),
            .y        (fighter_y[i]),
            .facing   (facing[i])
        );

        projectile_unit #(
            .owner    (fighter_idx_t'(i)),
            .lifetime (LIFETIME[i])
        ) i_proj (
            .clk          (clk),
            .rst          (rst),
            .tick         (tick),
            .fire_req     (fire_req[i]),
            .owner_facing (facing[i]),
            .fighter_x    (fighter_x),
            .fighter_y    (fighter_y),
            .alive        (alive),
            .active       (proj_active[i]),
            .x            (proj_x[i]),
            .y            (proj_y[i]),
            .dir          (),
            .hit          (hits[i])
        );
    end

    health_ledger i_ledger (
        .clk    (clk),
        .rst    (rst),
        .tick   (tick),
        .hits   (hits),
        .health (health),
        .alive  (alive)
    );

endmodule

`default_nettype wire

// ==== verif/arena_tb_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "arena_defs.svh"

module arena_tb_asserts (
    input logic                                 clk,
    input logic                                 rst,
    input logic                                 tick,
    input logic [`N_FIGHTERS-1:0]               proj_active,
    input arena_pkg::pos_t [`N_FIGHTERS-1:0]    proj_x,
    input arena_pkg::pos_t [`N_FIGHTERS-1:0]    proj_y,
    input arena_pkg::health_t [`N_FIGHTERS-1:0] health
);

    int unsigned fail_count = 0;

    tick_single: assert property (@(posedge clk) disable iff (rst) tick |=> !tick)
        else begin
            $error("tick stayed high for two cycles");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge clk) rst |=> (proj_active == '0 && !tick))
        else begin
            $error("projectile or tick active right after reset");
            fail_count++;
        end

    for (genvar i = 0; i < `N_FIGHTERS; i++) begin : g_unit
        proj_inside: assert property (@(posedge clk) disable iff (rst)
            proj_active[i] |-> (int'(proj_x[i]) + `PROJ_SIZE <= `ARENA_W &&
                                int'(proj_y[i]) + `PROJ_SIZE <= `ARENA_H))
            else begin
                $error("projectile %0d outside the arena", i);
                fail_count++;
            end

        health_down: assert property (@(posedge clk) disable iff (rst)
            !$past(rst) |-> health[i] <= $past(health[i]))
            else begin
                $error("health of fighter %0d went up", i);
                fail_count++;
            end
    end

endmodule

bind arena_top arena_tb_asserts i_asserts (
    .clk         (clk),
    .rst         (rst),
    .tick        (tick),
    .proj_active (proj_active),
    .proj_x      (proj_x),
    .proj_y      (proj_y),
    .health      (health)
);

`default_nettype wire

// ==== verif/arena_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "arena_defs.svh"

module arena_tb;

    import arena_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RUN_TICKS = 2000;
    localparam longint WATCHDOG_NS = 64'd2 * RUN_TICKS * `GAME_TICK_CYCLES * CLK_PERIOD;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32+x^22+x^2+x+1

    localparam int START_X [`N_FIGHTERS] = '{60, 240, 60, 240};
    localparam int START_Y [`N_FIGHTERS] = '{40, 40, 180, 180};
    localparam int LIFE [`N_FIGHTERS] = '{`LIFE_MAGE, `LIFE_GUNMAN, `LIFE_SWORDMAN, `LIFE_FISTMAN};

    logic                           clk;
    logic                           rst;
    logic [`N_FIGHTERS-1:0]         move_req;
    dir_t [`N_FIGHTERS-1:0]         move_dir;
    logic [`N_FIGHTERS-1:0]         fire_req;
    logic                           tick;
    pos_t [`N_FIGHTERS-1:0]         fighter_x;
    pos_t [`N_FIGHTERS-1:0]         fighter_y;
    dir_t [`N_FIGHTERS-1:0]         facing;
    logic [`N_FIGHTERS-1:0]         proj_active;
    pos_t [`N_FIGHTERS-1:0]         proj_x;
    pos_t [`N_FIGHTERS-1:0]         proj_y;
    health_t [`N_FIGHTERS-1:0]      health;

    // reference model state
    int m_x [`N_FIGHTERS];
    int m_y [`N_FIGHTERS];
    int m_f [`N_FIGHTERS];
    int m_pa [`N_FIGHTERS];
    int m_px [`N_FIGHTERS];
    int m_py [`N_FIGHTERS];
    int m_pd [`N_FIGHTERS];
    int m_life [`N_FIGHTERS];
    int m_hp [`N_FIGHTERS];
    int m_cnt;
    int m_tick;
    bit model_valid = 1'b0;
    int tick_count = 0;
    logic [31:0] lfsr_state = 32'hb8e3_cd1f;

    arena_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .move_req    (move_req),
        .move_dir    (move_dir),
        .fire_req    (fire_req),
        .tick        (tick),
        .fighter_x   (fighter_x),
        .fighter_y   (fighter_y),
        .facing      (facing),
        .proj_active (proj_active),
        .proj_x      (proj_x),
        .proj_y      (proj_y),
        .health      (health)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic take_bit();
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
        return lfsr_state[0];
    endfunction

    function automatic bit boxes_hit(input int ax, input int ay, input int a_size,
                                     input int bx, input int by, input int b_size);
        return (ax < bx + b_size) && (bx < ax + a_size) &&
               (ay < by + b_size) && (by < ay + a_size);
    endfunction

    function automatic int delta_x(input int d, input int step);
        if (d == 2) return -step;     // left
        if (d == 3) return step;
        return 0;
    endfunction

    function automatic int delta_y(input int d, input int step);
        if (d == 0) return -step;     // up
        if (d == 1) return step;
        return 0;
    endfunction

    task automatic end_with_failure();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < `N_FIGHTERS; i++) begin
            m_x[i] = START_X[i];
            m_y[i] = START_Y[i];
            m_f[i] = 1;               // down
            m_pa[i] = 0;
            m_px[i] = 0;
            m_py[i] = 0;
            m_pd[i] = 1;
            m_life[i] = 0;
            m_hp[i] = `HEALTH_START;
        end
        m_cnt = 0;
        m_tick = 0;
    endtask

    task automatic step_model();
        int nx [`N_FIGHTERS];
        int ny [`N_FIGHTERS];
        int nf [`N_FIGHTERS];
        int hits [`N_FIGHTERS];
        bit alv [`N_FIGHTERS];
        int cx;
        int cy;
        int tgt;
        bit blocked;
        for (int i = 0; i < `N_FIGHTERS; i++) begin
            alv[i] = (m_hp[i] != 0);
            hits[i] = 0;
            nx[i] = m_x[i];
            ny[i] = m_y[i];
            nf[i] = m_f[i];
        end
        for (int i = 0; i < `N_FIGHTERS; i++) begin
            if (alv[i] && move_req[i]) begin
                nf[i] = int'(move_dir[i]);
                cx = m_x[i] + delta_x(nf[i], `MOVE_STEP);
                cy = m_y[i] + delta_y(nf[i], `MOVE_STEP);
                blocked = (cx < 0) || (cy < 0) || (cx + `CHAR_SIZE > `ARENA_W) ||
                          (cy + `CHAR_SIZE > `ARENA_H);
                for (int j = 0; j < `N_FIGHTERS; j++) begin
                    if (j != i && boxes_hit(cx, cy, `CHAR_SIZE, m_x[j], m_y[j], `CHAR_SIZE))
                        blocked = 1'b1;   // dead fighters still block
                end
                if (!blocked) begin
                    nx[i] = cx;
                    ny[i] = cy;
                end
            end
        end
        for (int i = 0; i < `N_FIGHTERS; i++) begin
            if (!m_pa[i]) begin
                if (fire_req[i] && alv[i]) begin
                    m_pa[i] = 1;
                    m_px[i] = m_x[i] + `PROJ_OFFSET;
                    m_py[i] = m_y[i] + `PROJ_OFFSET;
                    m_pd[i] = m_f[i];
                    m_life[i] = LIFE[i];
                end
            end else begin
                tgt = -1;
                for (int j = `N_FIGHTERS - 1; j >= 0; j--) begin
                    if (j != i && alv[j] &&
                        boxes_hit(m_px[i], m_py[i], `PROJ_SIZE, m_x[j], m_y[j], `CHAR_SIZE))
                        tgt = j;          // ends on lowest index
                end
                cx = m_px[i] + delta_x(m_pd[i], `PROJ_STEP);
                cy = m_py[i] + delta_y(m_pd[i], `PROJ_STEP);
                if (tgt >= 0) begin
                    hits[tgt]++;
                    m_pa[i] = 0;
                end else if (m_life[i] == 0) begin
                    m_pa[i] = 0;
                end else if (cx < 0 || cy < 0 || cx + `PROJ_SIZE > `ARENA_W ||
                             cy + `PROJ_SIZE > `ARENA_H) begin
                    m_pa[i] = 0;
                end else begin
                    m_px[i] = cx;
                    m_py[i] = cy;
                    m_life[i]--;
                end
            end
        end
        for (int i = 0; i < `N_FIGHTERS; i++) begin
            m_x[i] = nx[i];
            m_y[i] = ny[i];
            m_f[i] = nf[i];
            m_hp[i] = (m_hp[i] > hits[i]) ? m_hp[i] - hits[i] : 0;
        end
    endtask

    task automatic compare_all();
        check_val("tick", 32'(tick), m_tick);
        for (int i = 0; i < `N_FIGHTERS; i++) begin
            check_val($sformatf("fighter_x[%0d]", i), 32'(fighter_x[i]), m_x[i]);
            check_val($sformatf("fighter_y[%0d]", i), 32'(fighter_y[i]), m_y[i]);
            check_val($sformatf("facing[%0d]", i), 32'(facing[i]), m_f[i]);
            check_val($sformatf("proj_active[%0d]", i), 32'(proj_active[i]), m_pa[i]);
            check_val($sformatf("proj_x[%0d]", i), 32'(proj_x[i]), m_px[i]);
            check_val($sformatf("proj_y[%0d]", i), 32'(proj_y[i]), m_py[i]);
            check_val($sformatf("health[%0d]", i), 32'(health[i]), m_hp[i]);
        end
    endtask

    task automatic drive_random_cmds();
        logic req;
        logic [1:0] d;
        logic [2:0] f;
        for (int i = 0; i < `N_FIGHTERS; i++) begin
            req = take_bit();
            d[0] = take_bit();
            d[1] = take_bit();
            f[0] = take_bit();
            f[1] = take_bit();
            f[2] = take_bit();
            move_req[i] <= req;
            move_dir[i] <= dir_t'(d);
            fire_req[i] <= &f;        // one draw in eight
        end
    endtask

    // model follows the DUT edge by edge, compared before each update
    always @(posedge clk) begin
        if (model_valid) begin
            compare_all();
        end
        if (rst) begin
            reset_model();
            model_valid = 1'b1;
        end else begin
            if (m_tick) begin
                step_model();
                tick_count <= tick_count + 1;
            end
            m_tick = (m_cnt == `GAME_TICK_CYCLES - 1);
            m_cnt = (m_cnt + 1) % `GAME_TICK_CYCLES;
        end
    end

    // failures flagged by the bound checker
    always @(posedge clk) begin
        if (i_dut.i_asserts.fail_count != 0) begin
            $display("a concurrent assertion in the bound checker failed");
            end_with_failure();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired: run did not finish within %0d ns", WATCHDOG_NS);
        end_with_failure();
    end

    initial begin
        rst = 1'b1;
        move_req = '0;
        fire_req = '0;
        for (int i = 0; i < `N_FIGHTERS; i++) begin
            move_dir[i] = dir_up;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // mage and gunman walk into each other
        move_req <= 4'b0011;
        move_dir[0] <= dir_right;
        move_dir[1] <= dir_left;
        repeat (50 * `GAME_TICK_CYCLES) @(posedge clk);
        check_val("fighter gap", 32'(fighter_x[1]) - 32'(fighter_x[0]), `CHAR_SIZE);

        // gunman shoots the adjacent mage until it dies
        move_req <= '0;
        fire_req <= 4'b0010;
        repeat (60 * `GAME_TICK_CYCLES) @(posedge clk);
        check_val("health[0]", 32'(health[0]), 0);

        while (tick_count < RUN_TICKS) begin
            @(posedge clk);
            drive_random_cmds();
        end

        @(negedge clk);               // last edge fully checked
        if (i_dut.i_asserts.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("a concurrent assertion in the bound checker failed");
            end_with_failure();
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
rtl/arena_pkg.sv
rtl/game_tick_gen.sv
rtl/fighter_motion.sv
rtl/projectile_unit.sv
rtl/health_ledger.sv
rtl/arena_top.sv
verif/arena_tb_asserts.sv
verif/arena_tb.sv

// ==== Bender.yml ====
package:
  name: arena_core

sources:
  - include_dirs:
      - include
    files:
      - rtl/arena_pkg.sv
      - rtl/game_tick_gen.sv
      - rtl/fighter_motion.sv
      - rtl/projectile_unit.sv
      - rtl/health_ledger.sv
      - rtl/arena_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/arena_tb_asserts.sv
      - verif/arena_tb.sv
